// File: logic/dataPathPkg.sv
`default_nettype none

package dataPathPkg;

	////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////

	typedef enum logic [3:0] {
		ADD  = 4'd0,
		ADDI = 4'd1,
		ADDC = 4'd2,
		SUB  = 4'd3,
		SUBI = 4'd4,
		CMP  = 4'd5,
		CMPI = 4'd6,
		AND  = 4'd7,
		OR   = 4'd8,
		XOR  = 4'd9,
		MOV  = 4'd10,
		MOVI = 4'd11,
		LSH  = 4'd12,
		RSH  = 4'd13,
		ANDI = 4'd14,
		NOP  = 4'd15
	} aluOp;

	////////////////////////////////////////
	// Instruction word layout
	////////////////////////////////////////

	localparam int instrWidth = 16;
	localparam int regAddrWidth = 4;
	localparam int immWidth = 8;

	localparam int opMsb = 15;
	localparam int opLsb = 12;
	localparam int rDestMsb = 11;
	localparam int rDestLsb = 8;
	localparam int rSrcMsb = 3;
	localparam int rSrcLsb = 0;
	localparam int immMsb = 7;
	localparam int immLsb = 0;

	// Flag vector, C in the top bit down to N
	localparam int flagCount = 5;
	localparam int flagC = 4;
	localparam int flagL = 3;
	localparam int flagF = 2;
	localparam int flagZ = 1;
	localparam int flagN = 0;

endpackage

`default_nettype wire

// File: logic/instrDecode.sv
`timescale 1ns/100ps
`default_nettype none

module instrDecode #(
	parameter int dataWidth = 16
) (
	input wire logic [dataPathPkg::instrWidth-1:0] instr,
	output dataPathPkg::aluOp op,
	output logic [dataPathPkg::regAddrWidth-1:0] readRegA,
	output logic [dataPathPkg::regAddrWidth-1:0] readRegB,
	output logic selectImm,
	output logic [dataWidth-1:0] immExt,
	output logic writeIntent
);

	logic [dataPathPkg::immWidth-1:0] imm;

	////////////////////////////////////////
	// Field extraction
	////////////////////////////////////////

	// All sixteen codes are defined, so the cast never lands outside the enum
	assign op = dataPathPkg::aluOp'(instr[dataPathPkg::opMsb:dataPathPkg::opLsb]);

	// Port A always reads the destination, it is also the first operand
	assign readRegA = instr[dataPathPkg::rDestMsb:dataPathPkg::rDestLsb];
	assign readRegB = instr[dataPathPkg::rSrcMsb:dataPathPkg::rSrcLsb];

	assign imm = instr[dataPathPkg::immMsb:dataPathPkg::immLsb];

	// Sign extend the 8-bit immediate
	assign immExt = {{(dataWidth - dataPathPkg::immWidth){imm[dataPathPkg::immWidth-1]}}, imm};

	////////////////////////////////////////
	// Operand and write-back control
	////////////////////////////////////////

	always_comb begin
		case (op)
			dataPathPkg::ADDI,
			dataPathPkg::SUBI,
			dataPathPkg::CMPI,
			dataPathPkg::ANDI,
			dataPathPkg::MOVI: begin
				selectImm = 1'b1;
			end
			default: begin
				selectImm = 1'b0;
			end
		endcase
	end

	// Compares only touch flags
	always_comb begin
		case (op)
			dataPathPkg::CMP,
			dataPathPkg::CMPI,
			dataPathPkg::NOP: begin
				writeIntent = 1'b0;
			end
			default: begin
				writeIntent = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: logic/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile #(
	parameter int dataWidth = 16
) (
	input wire logic CLK,
	input wire logic rstN,
	input wire logic [dataPathPkg::regAddrWidth-1:0] readRegA,
	input wire logic [dataPathPkg::regAddrWidth-1:0] readRegB,
	output logic [dataWidth-1:0] regA,
	output logic [dataWidth-1:0] regB,
	input wire logic writeEn,
	input wire logic [dataPathPkg::regAddrWidth-1:0] writeReg,
	input wire logic [dataWidth-1:0] writeData
);

	localparam int regCount = 1 << dataPathPkg::regAddrWidth;

	logic [dataWidth-1:0] regs [regCount];
	logic [regCount-1:0] writeSel;

	// One-hot write enable per register
	always_comb begin
		writeSel = '0;
		writeSel[writeReg] = writeEn;
	end

	always_ff @(posedge CLK) begin
		for (int i = 0; i < regCount; i++) begin
			if (!rstN) begin
				regs[i] <= '0;
			end else if (writeSel[i]) begin
				regs[i] <= writeData;
			end
		end
	end

	// Read ports are combinational, a write is visible the cycle after its edge
	assign regA = regs[readRegA];
	assign regB = regs[readRegB];

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// Nothing moves unless the write strobe is up
	for (genvar g = 0; g < regCount; g++) begin : genHoldCheck
		assert property (@(posedge CLK) disable iff (!rstN)
			!writeEn |=> $stable(regs[g]));
	end

endmodule

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu #(
	parameter int dataWidth = 16
) (
	input wire dataPathPkg::aluOp op,
	input wire logic [dataWidth-1:0] a,
	input wire logic [dataWidth-1:0] b,
	input wire logic carryIn,
	output logic [dataWidth-1:0] aluResult,
	output logic [dataPathPkg::flagCount-1:0] flagsNext,
	output logic [dataPathPkg::flagCount-1:0] flagMask
);

	localparam int msb = dataWidth - 1;

	logic carryAdd;
	logic [dataWidth:0] sumWide;
	logic [dataWidth:0] diffWide;

	////////////////////////////////////////
	// Shared adder and subtractor
	////////////////////////////////////////

	// Only ADDC pulls in the stored carry
	assign carryAdd = (op == dataPathPkg::ADDC) ? carryIn : 1'b0;

	assign sumWide = {1'b0, a} + {1'b0, b} + {{dataWidth{1'b0}}, carryAdd};

	// Top bit of the difference is the borrow
	assign diffWide = {1'b0, a} - {1'b0, b};

	////////////////////////////////////////
	// Result and flags per opcode
	////////////////////////////////////////

	always_comb begin
		aluResult = '0;
		flagsNext = '0;
		flagMask = '0;
		case (op)
			dataPathPkg::ADD,
			dataPathPkg::ADDI,
			dataPathPkg::ADDC: begin
				aluResult = sumWide[msb:0];
				flagsNext[dataPathPkg::flagC] = sumWide[dataWidth];
				// Same input signs, different result sign
				flagsNext[dataPathPkg::flagF] = (a[msb] == b[msb]) && (sumWide[msb] != a[msb]);
				flagsNext[dataPathPkg::flagZ] = (sumWide[msb:0] == '0);
				flagMask[dataPathPkg::flagC] = 1'b1;
				flagMask[dataPathPkg::flagF] = 1'b1;
				flagMask[dataPathPkg::flagZ] = 1'b1;
			end
			dataPathPkg::SUB,
			dataPathPkg::SUBI: begin
				aluResult = diffWide[msb:0];
				flagsNext[dataPathPkg::flagC] = diffWide[dataWidth];
				// Opposite input signs and result sign flipped away from a
				flagsNext[dataPathPkg::flagF] = (a[msb] != b[msb]) && (diffWide[msb] != a[msb]);
				flagsNext[dataPathPkg::flagZ] = (diffWide[msb:0] == '0);
				flagMask[dataPathPkg::flagC] = 1'b1;
				flagMask[dataPathPkg::flagF] = 1'b1;
				flagMask[dataPathPkg::flagZ] = 1'b1;
			end
			dataPathPkg::CMP,
			dataPathPkg::CMPI: begin
				aluResult = diffWide[msb:0];
				flagsNext[dataPathPkg::flagL] = (a < b);
				flagsNext[dataPathPkg::flagN] = ($signed(a) < $signed(b));
				flagsNext[dataPathPkg::flagZ] = (a == b);
				flagMask[dataPathPkg::flagL] = 1'b1;
				flagMask[dataPathPkg::flagN] = 1'b1;
				flagMask[dataPathPkg::flagZ] = 1'b1;
			end
			dataPathPkg::AND,
			dataPathPkg::ANDI: begin
				aluResult = a & b;
			end
			dataPathPkg::OR: begin
				aluResult = a | b;
			end
			dataPathPkg::XOR: begin
				aluResult = a ^ b;
			end
			dataPathPkg::MOV,
			dataPathPkg::MOVI: begin
				aluResult = b;
			end
			// Shift amount from the low nibble of the source
			dataPathPkg::LSH: begin
				aluResult = a << b[3:0];
			end
			dataPathPkg::RSH: begin
				aluResult = a >> b[3:0];
			end
			default: begin
				aluResult = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: logic/resultStage.sv
`timescale 1ns/100ps
`default_nettype none

module resultStage #(
	parameter int dataWidth = 16
) (
	input wire logic CLK,
	input wire logic rstN,
	input wire logic instrValid,
	output logic instrReady,
	input wire logic writeIntent,
	output logic writeEn,
	input wire logic [dataPathPkg::regAddrWidth-1:0] destIn,
	input wire logic [dataWidth-1:0] aluResult,
	input wire logic [dataPathPkg::flagCount-1:0] flagsNext,
	input wire logic [dataPathPkg::flagCount-1:0] flagMask,
	output logic [dataPathPkg::flagCount-1:0] flags,
	output logic resultValid,
	input wire logic resultReady,
	output logic [dataWidth-1:0] result,
	output logic [dataPathPkg::regAddrWidth-1:0] resultDest
);

	logic accept;

	////////////////////////////////////////
	// Handshake
	////////////////////////////////////////

	// Room for a new record when the slot is empty or being drained
	assign instrReady = !resultValid || resultReady;
	assign accept = instrValid && instrReady;

	// Register write lands on the same edge as the record
	assign writeEn = accept && writeIntent;

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			resultValid <= 1'b0;
			flags <= '0;
		end else begin
			if (accept) begin
				resultValid <= 1'b1;
				// Untouched flags keep their old value
				flags <= (flags & ~flagMask) | (flagsNext & flagMask);
			end else if (resultReady) begin
				resultValid <= 1'b0;
			end
		end
	end

	// Record payload
	always_ff @(posedge CLK) begin
		if (accept) begin
			result <= aluResult;
			resultDest <= destIn;
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// Stalled record must not move
	assert property (@(posedge CLK) disable iff (!rstN)
		resultValid && !resultReady |=>
			resultValid && $stable(result) && $stable(resultDest) && $stable(flags));

endmodule

`default_nettype wire

// File: logic/dataPath.sv
`timescale 1ns/100ps
`default_nettype none

module dataPath #(
	parameter int dataWidth = 16
) (
	input wire logic CLK,
	input wire logic rstN,
	input wire logic instrValid,
	input wire logic [dataPathPkg::instrWidth-1:0] instr,
	output logic instrReady,
	output logic resultValid,
	input wire logic resultReady,
	output logic [dataWidth-1:0] result,
	output logic [dataPathPkg::regAddrWidth-1:0] resultDest,
	output logic [dataPathPkg::flagCount-1:0] flags
);

	dataPathPkg::aluOp op;
	logic [dataPathPkg::regAddrWidth-1:0] readRegA;
	logic [dataPathPkg::regAddrWidth-1:0] readRegB;
	logic selectImm;
	logic [dataWidth-1:0] immExt;
	logic writeIntent;
	logic [dataWidth-1:0] regA;
	logic [dataWidth-1:0] regB;
	logic [dataWidth-1:0] operandB;
	logic [dataWidth-1:0] aluResult;
	logic [dataPathPkg::flagCount-1:0] flagsNext;
	logic [dataPathPkg::flagCount-1:0] flagMask;
	logic writeEn;

	instrDecode #(.dataWidth(dataWidth)) decode (
		.instr(instr), .op(op), .readRegA(readRegA), .readRegB(readRegB),
		.selectImm(selectImm), .immExt(immExt), .writeIntent(writeIntent)
	);

	// Destination doubles as write address and first operand
	regFile #(.dataWidth(dataWidth)) regs (
		.CLK(CLK), .rstN(rstN), .readRegA(readRegA), .readRegB(readRegB),
		.regA(regA), .regB(regB), .writeEn(writeEn), .writeReg(readRegA),
		.writeData(aluResult)
	);

	// Immediate or register as second operand
	assign operandB = selectImm ? immExt : regB;

	alu #(.dataWidth(dataWidth)) aluUnit (
		.op(op), .a(regA), .b(operandB), .carryIn(flags[dataPathPkg::flagC]),
		.aluResult(aluResult), .flagsNext(flagsNext), .flagMask(flagMask)
	);

	resultStage #(.dataWidth(dataWidth)) stage (
		.CLK(CLK), .rstN(rstN), .instrValid(instrValid), .instrReady(instrReady),
		.writeIntent(writeIntent), .writeEn(writeEn), .destIn(readRegA),
		.aluResult(aluResult), .flagsNext(flagsNext), .flagMask(flagMask),
		.flags(flags), .resultValid(resultValid), .resultReady(resultReady),
		.result(result), .resultDest(resultDest)
	);

endmodule

`default_nettype wire

// File: dv/dataPathTb.sv
`timescale 1ns/100ps
`default_nettype none

module dataPathTb;

	localparam int dataWidth = 16;
	localparam int numEntries = 42;
	localparam int timeoutCycles = numEntries * 20;

	logic CLK = 1'b0;
	logic rstN;
	logic instrValid;
	logic [dataPathPkg::instrWidth-1:0] instr;
	logic instrReady;
	logic resultValid;
	logic resultReady;
	logic [dataWidth-1:0] result;
	logic [dataPathPkg::regAddrWidth-1:0] resultDest;
	logic [dataPathPkg::flagCount-1:0] flags;

	// Stimulus and expected record per entry
	logic [dataPathPkg::instrWidth-1:0] instrTab [numEntries];
	logic [dataWidth-1:0] resTab [numEntries];
	logic [dataPathPkg::regAddrWidth-1:0] destTab [numEntries];
	logic [dataPathPkg::flagCount-1:0] flagTab [numEntries];

	int fillIdx = 0;
	int sendIdx = 0;
	int recvIdx = 0;
	int errors = 0;
	int cycleCount = 0;

	dataPath #(.dataWidth(dataWidth)) dut (
		.CLK(CLK), .rstN(rstN), .instrValid(instrValid), .instr(instr),
		.instrReady(instrReady), .resultValid(resultValid), .resultReady(resultReady),
		.result(result), .resultDest(resultDest), .flags(flags)
	);

	always #50 CLK = ~CLK;

	////////////////////////////////////////
	// Encoding and table helpers
	////////////////////////////////////////

	function automatic logic [15:0] encodeReg(input dataPathPkg::aluOp op,
			input logic [3:0] rd, input logic [3:0] rs);
		return {op, rd, 4'h0, rs};
	endfunction

	function automatic logic [15:0] encodeImm(input dataPathPkg::aluOp op,
			input logic [3:0] rd, input logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	task automatic addEntry(input logic [15:0] word, input logic [dataWidth-1:0] res,
			input logic [3:0] dest, input logic [4:0] flg);
		instrTab[fillIdx] = word;
		resTab[fillIdx] = res;
		destTab[fillIdx] = dest;
		flagTab[fillIdx] = flg;
		fillIdx++;
	endtask

	// Flags column is {C, L, F, Z, N}
	task automatic buildTable();
		// Reset state, loads and moves
		addEntry(encodeReg(dataPathPkg::MOV, 4'h5, 4'h9), 16'h0000, 4'h5, 5'b00000);
		addEntry(encodeImm(dataPathPkg::MOVI, 4'h1, 8'h12), 16'h0012, 4'h1, 5'b00000);
		addEntry(encodeImm(dataPathPkg::MOVI, 4'h2, 8'h80), 16'hFF80, 4'h2, 5'b00000);
		addEntry(encodeImm(dataPathPkg::MOVI, 4'h3, 8'h7F), 16'h007F, 4'h3, 5'b00000);
		addEntry(encodeReg(dataPathPkg::MOV, 4'h4, 4'h2), 16'hFF80, 4'h4, 5'b00000);
		addEntry(encodeReg(dataPathPkg::MOV, 4'h6, 4'h1), 16'h0012, 4'h6, 5'b00000);
		// Adds, with carry out, overflow and zero
		addEntry(encodeReg(dataPathPkg::ADD, 4'h1, 4'h3), 16'h0091, 4'h1, 5'b00000);
		addEntry(encodeImm(dataPathPkg::ADDI, 4'h4, 8'h80), 16'hFF00, 4'h4, 5'b10000);
		addEntry(encodeImm(dataPathPkg::MOVI, 4'h7, 8'hFF), 16'hFFFF, 4'h7, 5'b10000);
		addEntry(encodeImm(dataPathPkg::MOVI, 4'h8, 8'h01), 16'h0001, 4'h8, 5'b10000);
		addEntry(encodeReg(dataPathPkg::RSH, 4'h7, 4'h8), 16'h7FFF, 4'h7, 5'b10000);
		addEntry(encodeImm(dataPathPkg::ADDI, 4'h7, 8'h01), 16'h8000, 4'h7, 5'b00100);
		addEntry(encodeImm(dataPathPkg::ADDI, 4'h8, 8'hFF), 16'h0000, 4'h8, 5'b10010);
		// Subtracts
		addEntry(encodeReg(dataPathPkg::SUB, 4'h1, 4'h3), 16'h0012, 4'h1, 5'b00000);
		addEntry(encodeImm(dataPathPkg::SUBI, 4'h3, 8'h7F), 16'h0000, 4'h3, 5'b00010);
		addEntry(encodeReg(dataPathPkg::SUB, 4'h3, 4'h6), 16'hFFEE, 4'h3, 5'b10000);
		addEntry(encodeImm(dataPathPkg::SUBI, 4'h7, 8'h01), 16'h7FFF, 4'h7, 5'b00100);
		// Compares leave registers alone
		addEntry(encodeReg(dataPathPkg::CMP, 4'h1, 4'h2), 16'h0092, 4'h1, 5'b01100);
		addEntry(encodeReg(dataPathPkg::CMP, 4'h2, 4'h1), 16'hFF6E, 4'h2, 5'b00101);
		addEntry(encodeReg(dataPathPkg::CMP, 4'h6, 4'h1), 16'h0000, 4'h6, 5'b00110);
		addEntry(encodeImm(dataPathPkg::CMPI, 4'h7, 8'h80), 16'h807F, 4'h7, 5'b01100);
		addEntry(encodeImm(dataPathPkg::CMPI, 4'h4, 8'h80), 16'hFF80, 4'h4, 5'b01101);
		addEntry(encodeReg(dataPathPkg::MOV, 4'h9, 4'h1), 16'h0012, 4'h9, 5'b01101);
		addEntry(encodeReg(dataPathPkg::MOV, 4'h9, 4'h4), 16'hFF00, 4'h9, 5'b01101);
		// L and N stay set through the adds
		addEntry(encodeReg(dataPathPkg::ADD, 4'h9, 4'h9), 16'hFE00, 4'h9, 5'b11001);
		addEntry(encodeReg(dataPathPkg::ADDC, 4'h6, 4'h1), 16'h0025, 4'h6, 5'b01001);
		addEntry(encodeReg(dataPathPkg::ADDC, 4'h6, 4'h6), 16'h004A, 4'h6, 5'b01001);
		addEntry(encodeReg(dataPathPkg::ADD, 4'h4, 4'h4), 16'hFE00, 4'h4, 5'b11001);
		addEntry(encodeReg(dataPathPkg::ADDC, 4'h8, 4'h8), 16'h0001, 4'h8, 5'b01001);
		// Logic and shifts keep every flag
		addEntry(encodeReg(dataPathPkg::AND, 4'h2, 4'h3), 16'hFF80, 4'h2, 5'b01001);
		addEntry(encodeReg(dataPathPkg::OR, 4'h1, 4'h6), 16'h005A, 4'h1, 5'b01001);
		addEntry(encodeReg(dataPathPkg::XOR, 4'h3, 4'h2), 16'h006E, 4'h3, 5'b01001);
		addEntry(encodeImm(dataPathPkg::ANDI, 4'h9, 8'h0F), 16'h0000, 4'h9, 5'b01001);
		addEntry(encodeImm(dataPathPkg::MOVI, 4'hA, 8'h04), 16'h0004, 4'hA, 5'b01001);
		addEntry(encodeReg(dataPathPkg::LSH, 4'h1, 4'hA), 16'h05A0, 4'h1, 5'b01001);
		addEntry(encodeReg(dataPathPkg::RSH, 4'h3, 4'hA), 16'h0006, 4'h3, 5'b01001);
		addEntry(encodeReg(dataPathPkg::LSH, 4'h7, 4'h8), 16'hFFFE, 4'h7, 5'b01001);
		addEntry(encodeReg(dataPathPkg::NOP, 4'h0, 4'h0), 16'h0000, 4'h0, 5'b01001);
		addEntry(encodeReg(dataPathPkg::MOV, 4'hB, 4'h7), 16'hFFFE, 4'hB, 5'b01001);
		addEntry(encodeReg(dataPathPkg::MOV, 4'h0, 4'h3), 16'h0006, 4'h0, 5'b01001);
		addEntry(encodeReg(dataPathPkg::SUB, 4'h0, 4'h1), 16'hFA66, 4'h0, 5'b11001);
		addEntry(encodeReg(dataPathPkg::MOV, 4'hC, 4'h0), 16'hFA66, 4'hC, 5'b11001);
	endtask

	////////////////////////////////////////
	// Record check
	////////////////////////////////////////

	task automatic checkRecord();
		if (recvIdx >= numEntries) begin
			$display("A record for register %0d arrived with no table entry left", resultDest);
			errors++;
		end else begin
			assert (result === resTab[recvIdx]) else begin
				$display("Fail result entry %0d: expected %h, got %h",
					recvIdx, resTab[recvIdx], result);
				errors++;
			end
			assert (resultDest === destTab[recvIdx]) else begin
				$display("Fail resultDest entry %0d: expected %h, got %h",
					recvIdx, destTab[recvIdx], resultDest);
				errors++;
			end
			assert (flags === flagTab[recvIdx]) else begin
				$display("Fail flags entry %0d: expected %h, got %h",
					recvIdx, flagTab[recvIdx], flags);
				errors++;
			end
			recvIdx++;
		end
	endtask

	// Run limit
	always @(posedge CLK) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("Timeout after %0d cycles, only %0d of %0d records received, %0d errors",
				cycleCount, recvIdx, numEntries, errors);
			$display("TEST FAILED");
			$finish;
		end
	end

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial begin
		void'($urandom(96906));
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		resultReady = 1'b0;
		buildTable();

		repeat (2) @(posedge CLK);
		@(negedge CLK);
		rstN = 1'b1;
		#10;
		assert (resultValid === 1'b0) else begin
			$display("Fail resultValid after reset: expected 0, got %h", resultValid);
			errors++;
		end
		assert (instrReady === 1'b1) else begin
			$display("Fail instrReady after reset: expected 1, got %h", instrReady);
			errors++;
		end
		assert (flags === 5'b00000) else begin
			$display("Fail flags after reset: expected 00, got %h", flags);
			errors++;
		end

		// Sample 10 ns after the falling edge, well before the next rise
		while (recvIdx < numEntries) begin
			@(negedge CLK);
			if (sendIdx < numEntries) begin
				instrValid = 1'b1;
				instr = instrTab[sendIdx];
			end else begin
				instrValid = 1'b0;
			end
			resultReady = ($urandom_range(1, 0) == 1);
			#10;
			if (resultValid && resultReady) begin
				checkRecord();
			end
			if (instrValid && instrReady) begin
				sendIdx++;
			end
		end

		// Nothing more may come out
		repeat (5) begin
			@(negedge CLK);
			instrValid = 1'b0;
			resultReady = 1'b1;
			#10;
			if (resultValid) begin
				checkRecord();
			end
		end

		$display("Run finished with %0d errors", errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
logic/dataPathPkg.sv
logic/instrDecode.sv
logic/regFile.sv
logic/alu.sv
logic/resultStage.sv
logic/dataPath.sv
dv/dataPathTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = dataPathTb
FILELIST = flist.f
BUILDDIR = obj_dir
LOG      = sim.log
FAILMSG  = TEST FAILED

.PHONY: sim clean

# Build, run, then look for the fail message in the log
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAILMSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILDDIR) $(LOG)
